/* source/afu_bus_pkg.sv */
// memory-side bus formats shared by the producer, buffer and consumer
// a command is a cache-line address plus a tag, with reads only
// a response word is 72 bits, and its kind says which view is valid
// both views keep the tag in the top byte

package afu_bus_pkg;

  // widths
  localparam int tag_width          = 8;
  localparam int line_address_width = 56;
  localparam int payload_width      = 64;
  localparam int fault_code_width   = 8;

  // one stored command, address above tag
  localparam int command_word_width = line_address_width + tag_width;

  // what a returning response carries
  typedef enum logic {
    response_data  = 1'b0,
    response_fault = 1'b1
  } response_kind_t;

  // data response, the read payload
  typedef struct packed {
    logic [tag_width-1:0]     tag;
    logic [payload_width-1:0] payload;
  } response_data_view_t;

  // fault response, code and faulting line address
  typedef struct packed {
    logic [tag_width-1:0]          tag;
    logic [fault_code_width-1:0]   fault_code;
    logic [line_address_width-1:0] fault_address;
  } response_fault_view_t;

  // same 72 bits, two decodes
  typedef union packed {
    response_data_view_t  data_view;
    response_fault_view_t fault_view;
  } response_word_u;

endpackage

/* source/afu_regs_pkg.sv */
// host-visible register map, one 64-bit word per index
// control is write-only and reads back as zero

package afu_regs_pkg;

  localparam int reg_address_width = 3;

  // word indices
  localparam logic [reg_address_width-1:0] reg_base_address = 3'd0;
  localparam logic [reg_address_width-1:0] reg_line_count   = 3'd1;
  localparam logic [reg_address_width-1:0] reg_control      = 3'd2;
  localparam logic [reg_address_width-1:0] reg_status       = 3'd3;
  localparam logic [reg_address_width-1:0] reg_result       = 3'd4;
  localparam logic [reg_address_width-1:0] reg_fault_count  = 3'd5;

  // control bits
  localparam int control_start_bit = 0;

  // status bits, last fault code is a byte from bit 8
  localparam int status_running_bit    = 0;
  localparam int status_done_bit       = 1;
  localparam int status_last_fault_lsb = 8;

endpackage

/* source/cu_read_engine.sv */
// read command producer, one command per line of the job
// base and count are sampled at job_start, later writes do not affect
// a running job; a count of zero produces no commands
// tag is the low byte of the line index

`timescale 1ns/1ns

module cu_read_engine import afu_bus_pkg::*; (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          job_start,
  input  logic [line_address_width-1:0] base_address,
  input  logic [31:0]                   line_count,
  input  logic                          buffer_full,
  output logic                          push,
  output logic [line_address_width-1:0] push_address,
  output logic [tag_width-1:0]          push_tag
);

  logic                          active;
  logic [line_address_width-1:0] base_q;
  logic [31:0]                   count_q;
  logic [31:0]                   line_index;
  logic                          last_line;

  ////////////////////////////////////////
  // line walk
  ////////////////////////////////////////

  assign last_line = (line_index == count_q - 32'd1);

  always_ff @(posedge clock) begin
    if (reset) begin
      active     <= 1'b0;
      line_index <= '0;
    end else if (job_start) begin
      active     <= (line_count != 32'd0);
      line_index <= '0;
    end else if (push) begin
      line_index <= line_index + 32'd1;
      if (last_line) begin
        active <= 1'b0;
      end
    end
  end

  // job parameters held for the whole walk
  always_ff @(posedge clock) begin
    if (job_start) begin
      base_q  <= base_address;
      count_q <= line_count;
    end
  end

  ////////////////////////////////////////
  // command out
  ////////////////////////////////////////

  // stall while the buffer reports full
  assign push         = active && !buffer_full;
  assign push_address = base_q + line_address_width'(line_index);
  assign push_tag     = line_index[tag_width-1:0];

  // never pushes past the last line of the job
  push_within_job: assert property (
    @(posedge clock) disable iff (reset) push |-> line_index < count_q
  );

endmodule

/* source/command_buffer.sv */
// command FIFO with credit-limited issue to the memory side
// command_depth must be a power of two so the pointers wrap freely
// max_credits must not exceed 2**tag_width, keeping live tags unique
// every response_valid returns exactly one credit

`timescale 1ns/1ns

module command_buffer import afu_bus_pkg::*; #(
  parameter int command_depth = 8,
  parameter int max_credits   = 4
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          push,
  input  logic [line_address_width-1:0] push_address,
  input  logic [tag_width-1:0]          push_tag,
  input  logic                          response_valid,
  output logic                          buffer_full,
  output logic                          command_valid,
  output logic [line_address_width-1:0] command_address,
  output logic [tag_width-1:0]          command_tag
);

  localparam int pointer_width = $clog2(command_depth);
  localparam int credit_width  = $clog2(max_credits + 1);

  logic [command_word_width-1:0] fifo_mem [command_depth];
  logic [pointer_width-1:0]      write_pointer;
  logic [pointer_width-1:0]      read_pointer;
  logic [pointer_width:0]        entry_count;
  logic [credit_width-1:0]       credits;
  logic                          issue;

  assign buffer_full = (entry_count == (pointer_width + 1)'(command_depth));

  // only entries already stored may issue, and only with a credit in hand
  assign issue = (entry_count != '0) && (credits != '0);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (push) begin
      fifo_mem[write_pointer] <= {push_address, push_tag};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      write_pointer <= '0;
      read_pointer  <= '0;
      entry_count   <= '0;
    end else begin
      if (push) begin
        write_pointer <= write_pointer + pointer_width'(1);
      end
      if (issue) begin
        read_pointer <= read_pointer + pointer_width'(1);
      end
      entry_count <= entry_count + (pointer_width + 1)'(push) - (pointer_width + 1)'(issue);
    end
  end

  ////////////////////////////////////////
  // issue and credits
  ////////////////////////////////////////

  // issue and credit return can land on the same edge
  always_ff @(posedge clock) begin
    if (reset) begin
      command_valid <= 1'b0;
      credits       <= credit_width'(max_credits);
    end else begin
      command_valid <= issue;
      credits       <= credits - credit_width'(issue) + credit_width'(response_valid);
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      {command_address, command_tag} <= fifo_mem[read_pointer];
    end
  end

  credits_in_range: assert property (
    @(posedge clock) disable iff (reset) credits <= credit_width'(max_credits)
  );

  // the producer must stall on full
  no_push_when_full: assert property (
    @(posedge clock) disable iff (reset) push |-> !buffer_full
  );

  // memory side must not answer a command it was never sent
  no_response_when_idle: assert property (
    @(posedge clock) disable iff (reset)
      response_valid |-> credits != credit_width'(max_credits)
  );

endmodule

/* source/response_control.sv */
// response consumer, sums data payloads and counts faults
// the job length is sampled at job_start
// a faulted line still counts toward completion and is not replayed
// job_done stays high until the next job_start

`timescale 1ns/1ns

module response_control import afu_bus_pkg::*; (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        job_start,
  input  logic [31:0]                 line_count,
  input  logic                        response_valid,
  input  response_kind_t              response_kind,
  input  response_word_u              response_word,
  output logic                        job_done,
  output logic [payload_width-1:0]    result_sum,
  output logic [31:0]                 fault_count,
  output logic [fault_code_width-1:0] last_fault_code
);

  logic [31:0] target_count;
  logic [31:0] response_count;
  logic        last_response;

  assign last_response = (response_count + 32'd1 == target_count);

  ////////////////////////////////////////
  // decode and accumulate
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      job_done        <= 1'b0;
      result_sum      <= '0;
      fault_count     <= '0;
      last_fault_code <= '0;
      response_count  <= '0;
      target_count    <= '0;
    end else if (job_start) begin
      // an empty job is done right away
      job_done        <= (line_count == 32'd0);
      result_sum      <= '0;
      fault_count     <= '0;
      last_fault_code <= '0;
      response_count  <= '0;
      target_count    <= line_count;
    end else if (response_valid) begin
      response_count <= response_count + 32'd1;
      case (response_kind)
        response_data: begin
          // wraps at 64 bits
          result_sum <= result_sum + response_word.data_view.payload;
        end
        response_fault: begin
          fault_count     <= fault_count + 32'd1;
          last_fault_code <= response_word.fault_view.fault_code;
        end
      endcase
      if (last_response) begin
        job_done <= 1'b1;
      end
    end
  end

  // all commands of the job are answered once done is up
  no_response_after_done: assert property (
    @(posedge clock) disable iff (reset) job_done |-> !response_valid
  );

endmodule

/* source/mmio_regs.sv */
// host register file, 64-bit words at 3-bit indices
// a start write is dropped while a job runs
// read data follows the read strobe by one cycle
// unmapped indices and the control word read back as zero

`timescale 1ns/1ns

module mmio_regs import afu_bus_pkg::*, afu_regs_pkg::*; (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          mmio_write,
  input  logic                          mmio_read,
  input  logic [reg_address_width-1:0]  mmio_address,
  input  logic [63:0]                   mmio_write_data,
  input  logic                          job_done,
  input  logic [payload_width-1:0]      result_sum,
  input  logic [31:0]                   fault_count,
  input  logic [fault_code_width-1:0]   last_fault_code,
  output logic [63:0]                   mmio_read_data,
  output logic                          mmio_read_valid,
  output logic                          job_start,
  output logic [line_address_width-1:0] base_address,
  output logic [31:0]                   line_count
);

  logic        running;
  logic        job_done_q;
  logic        done_rise;
  logic        start_request;
  logic [63:0] status_word;
  logic [63:0] read_word;

  assign start_request = mmio_write && (mmio_address == reg_control) &&
                         mmio_write_data[control_start_bit] && !running;
  assign done_rise     = job_done && !job_done_q;

  ////////////////////////////////////////
  // config, start and running
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      base_address <= '0;
      line_count   <= '0;
      job_start    <= 1'b0;
      running      <= 1'b0;
      job_done_q   <= 1'b0;
    end else begin
      if (mmio_write && mmio_address == reg_base_address) begin
        base_address <= mmio_write_data[line_address_width-1:0];
      end
      if (mmio_write && mmio_address == reg_line_count) begin
        line_count <= mmio_write_data[31:0];
      end
      job_start  <= start_request;
      job_done_q <= job_done;
      // old done is still high while the new job starts, so no false rise
      if (start_request) begin
        running <= 1'b1;
      end else if (done_rise) begin
        running <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // readback
  ////////////////////////////////////////

  always_comb begin
    status_word                                                   = '0;
    status_word[status_running_bit]                               = running;
    status_word[status_done_bit]                                  = job_done;
    status_word[status_last_fault_lsb +: fault_code_width]        = last_fault_code;
    case (mmio_address)
      reg_base_address: read_word = 64'(base_address);
      reg_line_count:   read_word = 64'(line_count);
      reg_status:       read_word = status_word;
      reg_result:       read_word = 64'(result_sum);
      reg_fault_count:  read_word = 64'(fault_count);
      default:          read_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mmio_read_valid <= 1'b0;
    end else begin
      mmio_read_valid <= mmio_read;
    end
  end

  always_ff @(posedge clock) begin
    if (mmio_read) begin
      mmio_read_data <= read_word;
    end
  end

endmodule

/* source/mini_afu.sv */
// top level of the read accelerator
// host side is the MMIO strobes, memory side is command out and response in
// one synchronous reset covers every block

`timescale 1ns/1ns

module mini_afu import afu_bus_pkg::*, afu_regs_pkg::*; #(
  parameter int command_depth = 8,
  parameter int max_credits   = 4
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          mmio_write,
  input  logic                          mmio_read,
  input  logic [reg_address_width-1:0]  mmio_address,
  input  logic [63:0]                   mmio_write_data,
  output logic [63:0]                   mmio_read_data,
  output logic                          mmio_read_valid,
  output logic                          command_valid,
  output logic [line_address_width-1:0] command_address,
  output logic [tag_width-1:0]          command_tag,
  input  logic                          response_valid,
  input  response_kind_t                response_kind,
  input  response_word_u                response_word
);

  logic                          job_start;
  logic [line_address_width-1:0] base_address;
  logic [31:0]                   line_count;
  logic                          push;
  logic [line_address_width-1:0] push_address;
  logic [tag_width-1:0]          push_tag;
  logic                          buffer_full;
  logic                          job_done;
  logic [payload_width-1:0]      result_sum;
  logic [31:0]                   fault_count;
  logic [fault_code_width-1:0]   last_fault_code;

  ////////////////////////////////////////
  // host registers
  ////////////////////////////////////////

  mmio_regs mmio_regs_inst (
    .clock           (clock),
    .reset           (reset),
    .mmio_write      (mmio_write),
    .mmio_read       (mmio_read),
    .mmio_address    (mmio_address),
    .mmio_write_data (mmio_write_data),
    .job_done        (job_done),
    .result_sum      (result_sum),
    .fault_count     (fault_count),
    .last_fault_code (last_fault_code),
    .mmio_read_data  (mmio_read_data),
    .mmio_read_valid (mmio_read_valid),
    .job_start       (job_start),
    .base_address    (base_address),
    .line_count      (line_count)
  );

  ////////////////////////////////////////
  // command path
  ////////////////////////////////////////

  cu_read_engine cu_read_engine_inst (
    .clock        (clock),
    .reset        (reset),
    .job_start    (job_start),
    .base_address (base_address),
    .line_count   (line_count),
    .buffer_full  (buffer_full),
    .push         (push),
    .push_address (push_address),
    .push_tag     (push_tag)
  );

  command_buffer #(
    .command_depth (command_depth),
    .max_credits   (max_credits)
  ) command_buffer_inst (
    .clock           (clock),
    .reset           (reset),
    .push            (push),
    .push_address    (push_address),
    .push_tag        (push_tag),
    .response_valid  (response_valid),
    .buffer_full     (buffer_full),
    .command_valid   (command_valid),
    .command_address (command_address),
    .command_tag     (command_tag)
  );

  ////////////////////////////////////////
  // response path
  ////////////////////////////////////////

  response_control response_control_inst (
    .clock           (clock),
    .reset           (reset),
    .job_start       (job_start),
    .line_count      (line_count),
    .response_valid  (response_valid),
    .response_kind   (response_kind),
    .response_word   (response_word),
    .job_done        (job_done),
    .result_sum      (result_sum),
    .fault_count     (fault_count),
    .last_fault_code (last_fault_code)
  );

endmodule

/* dv/mini_afu_tb.sv */
// clocked testbench for mini_afu with a memory-side host model
// the host model answers outstanding commands in random order from a fixed seed
// two jobs run back to back; the first holds responses to exercise the credit limit
// the run is bounded by a watchdog sized from the total line count

`timescale 1ns/1ns

module mini_afu_tb import afu_bus_pkg::*, afu_regs_pkg::*;;

  localparam int max_credits = 4;

  logic                          clock;
  logic                          reset;
  logic                          mmio_write;
  logic                          mmio_read;
  logic [reg_address_width-1:0]  mmio_address;
  logic [63:0]                   mmio_write_data;
  logic [63:0]                   mmio_read_data;
  logic                          mmio_read_valid;
  logic                          command_valid;
  logic [line_address_width-1:0] command_address;
  logic [tag_width-1:0]          command_tag;
  logic                          response_valid;
  response_kind_t                response_kind;
  response_word_u                response_word;

  integer seed = 26;
  int     error_count;
  int     check_count;
  int     total_lines;

  // host model state with one {tag, address} word per outstanding command
  logic [63:0]                   pool [$];
  logic [line_address_width-1:0] job_base;
  int                            job_count;
  int                            next_index;
  bit                            hold_responses;
  int                            return_percent;
  logic [63:0]                   expected_sum;
  logic [31:0]                   expected_faults;
  logic [7:0]                    expected_last_code;

  mini_afu #(
    .command_depth (8),
    .max_credits   (max_credits)
  ) dut (
    .clock           (clock),
    .reset           (reset),
    .mmio_write      (mmio_write),
    .mmio_read       (mmio_read),
    .mmio_address    (mmio_address),
    .mmio_write_data (mmio_write_data),
    .mmio_read_data  (mmio_read_data),
    .mmio_read_valid (mmio_read_valid),
    .command_valid   (command_valid),
    .command_address (command_address),
    .command_tag     (command_tag),
    .response_valid  (response_valid),
    .response_kind   (response_kind),
    .response_word   (response_word)
  );

  always #20 clock = ~clock;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] random_word();
    random_word = $random(seed);
  endfunction

  // inputs change 2 ns after the rising edge
  task automatic step_cycle();
    @(posedge clock);
    #2;
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    assert (expected == actual) else begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_condition(input string what, input bit ok);
    check_count++;
    assert (ok) else begin
      $display("[ERROR] %s", what);
      error_count++;
    end
  endtask

  task automatic write_register(input logic [reg_address_width-1:0] address,
                                input logic [63:0] data);
    mmio_write      = 1'b1;
    mmio_address    = address;
    mmio_write_data = data;
    step_cycle();
    mmio_write = 1'b0;
  endtask

  task automatic read_register(input logic [reg_address_width-1:0] address,
                               output logic [63:0] data);
    mmio_read    = 1'b1;
    mmio_address = address;
    step_cycle();
    mmio_read = 1'b0;
    check_condition("read data was not valid one cycle after the read strobe",
                    mmio_read_valid == 1'b1);
    data = mmio_read_data;
  endtask

  ////////////////////////////////////////
  // memory-side host model
  ////////////////////////////////////////

  task automatic record_command();
    check_condition("a command was issued beyond the line count", next_index < job_count);
    check_value("command address", 64'(job_base + line_address_width'(next_index)),
                64'(command_address));
    check_value("command tag", 64'(next_index[7:0]), 64'(command_tag));
    foreach (pool[i]) begin
      check_condition("a command reused a tag that is still outstanding",
                      pool[i][63:56] != command_tag);
    end
    pool.push_back({command_tag, command_address});
    next_index++;
    check_condition("outstanding commands exceeded the credit limit",
                    pool.size() <= max_credits);
  endtask

  task automatic send_response();
    int          index;
    logic [63:0] entry;
    logic [31:0] kind_draw;
    logic [31:0] code_draw;
    logic [63:0] payload;
    index = int'(random_word() % 32'(pool.size()));
    entry = pool[index];
    pool.delete(index);
    kind_draw = random_word();
    response_valid = 1'b1;
    // roughly one response in eight faults
    if (kind_draw[2:0] == 3'd0) begin
      code_draw = random_word();
      response_kind = response_fault;
      response_word.fault_view.tag           = entry[63:56];
      response_word.fault_view.fault_code    = code_draw[7:0];
      response_word.fault_view.fault_address = entry[55:0];
      expected_faults    = expected_faults + 32'd1;
      expected_last_code = code_draw[7:0];
    end else begin
      payload = {random_word(), random_word()};
      response_kind = response_data;
      response_word.data_view.tag     = entry[63:56];
      response_word.data_view.payload = payload;
      expected_sum = expected_sum + payload;
    end
  endtask

  always @(posedge clock) begin
    #2;
    response_valid = 1'b0;
    if (!reset) begin
      if (command_valid) begin
        record_command();
      end
      if (!hold_responses && pool.size() > 0 &&
          int'(random_word() % 32'd100) < return_percent) begin
        send_response();
      end
    end
  end

  ////////////////////////////////////////
  // job sequence
  ////////////////////////////////////////

  task automatic run_job(input logic [line_address_width-1:0] base, input int count,
                         input bit with_hold);
    logic [63:0] word;
    logic [63:0] status_word;
    int          issued;
    write_register(reg_base_address, 64'(base));
    write_register(reg_line_count, 64'(count));
    read_register(reg_base_address, word);
    check_value("base address readback", 64'(base), word);
    read_register(reg_line_count, word);
    check_value("line count readback", 64'(count), word);
    job_base           = base;
    job_count          = count;
    next_index         = 0;
    expected_sum       = '0;
    expected_faults    = '0;
    expected_last_code = '0;
    return_percent     = 20 + int'(random_word() % 32'd70);
    hold_responses     = with_hold;
    write_register(reg_control, 64'd1);
    repeat (3) step_cycle();
    // the job is running and must ignore this start
    write_register(reg_control, 64'd1);
    if (with_hold) begin
      repeat (60) step_cycle();
      check_value("outstanding during hold", 64'(max_credits), 64'(pool.size()));
      issued = next_index;
      repeat (10) step_cycle();
      check_value("commands issued during hold", 64'(issued), 64'(next_index));
      // release between edges so the host model sees it from the next cycle on
      @(negedge clock);
      hold_responses = 1'b0;
      step_cycle();
    end
    status_word = '0;
    while (!(status_word[status_done_bit] && !status_word[status_running_bit])) begin
      read_register(reg_status, status_word);
    end
    check_value("command count", 64'(count), 64'(next_index));
    check_value("outstanding after done", 64'd0, 64'(pool.size()));
    check_value("last fault code", 64'(expected_last_code),
                64'(status_word[status_last_fault_lsb +: fault_code_width]));
    read_register(reg_result, word);
    check_value("result sum", expected_sum, word);
    read_register(reg_fault_count, word);
    check_value("fault count", 64'(expected_faults), word);
  endtask

  initial begin
    logic [63:0] word;
    int          first_count;
    int          second_count;
    error_count     = 0;
    check_count     = 0;
    clock           = 1'b0;
    reset           = 1'b1;
    mmio_write      = 1'b0;
    mmio_read       = 1'b0;
    mmio_address    = '0;
    mmio_write_data = '0;
    response_valid  = 1'b0;
    response_kind   = response_data;
    response_word   = '0;
    hold_responses  = 1'b0;
    return_percent  = 50;
    job_base        = '0;
    job_count       = 0;
    next_index      = 0;
    first_count     = 24 + int'(random_word() % 32'd16);
    second_count    = 16 + int'(random_word() % 32'd24);
    total_lines     = first_count + second_count;
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b0;
    read_register(reg_status, word);
    check_value("status after reset", 64'd0, word);
    word = {random_word(), random_word()};
    run_job(word[line_address_width-1:0], first_count, 1'b1);
    word = {random_word(), random_word()};
    run_job(word[line_address_width-1:0], second_count, 1'b0);
    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog sized once the line counts are drawn
  initial begin
    #1;
    repeat (200 * total_lines + 1000) @(posedge clock);
    $display("watchdog expired before both jobs completed");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* flist.f */
source/afu_bus_pkg.sv
source/afu_regs_pkg.sv
source/cu_read_engine.sv
source/command_buffer.sv
source/response_control.sv
source/mmio_regs.sv
source/mini_afu.sv
dv/mini_afu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the mini_afu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f flist.f --top-module mini_afu_tb -o sim_mini_afu

output="$(./obj_dir/sim_mini_afu 2>&1)" || true
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
  exit 0
else
  echo "simulation did not report a pass"
  exit 1
fi
